//--- logic/hps_pkg.sv
// shared constants of the host I/O bridge for command codes, widths and key sequences
package hps_pkg;

	// bus and register widths
	localparam int CMD_W    = 16;
	localparam int CNT_W    = 6;
	localparam int DATA_W   = 8;
	localparam int ADDR_W   = 27;
	localparam int JOY_W    = 32;
	localparam int JOY_NUM  = 6;
	localparam int STATUS_W = 64;

	//////////////////////////////////////////////////
	// command bus codes
	localparam logic [CMD_W-1:0] CMD_CFG        = 16'h0001;
	localparam logic [CMD_W-1:0] CMD_JOY_0      = 16'h0002;
	localparam logic [CMD_W-1:0] CMD_JOY_1      = 16'h0003;
	localparam logic [CMD_W-1:0] CMD_JOY_2      = 16'h0010;
	localparam logic [CMD_W-1:0] CMD_JOY_3      = 16'h0011;
	localparam logic [CMD_W-1:0] CMD_JOY_4      = 16'h0012;
	localparam logic [CMD_W-1:0] CMD_JOY_5      = 16'h0013;
	localparam logic [CMD_W-1:0] CMD_KBD        = 16'h0005;
	localparam logic [CMD_W-1:0] CMD_STATUS     = 16'h001E;
	localparam logic [CMD_W-1:0] CMD_STATUS_SET = 16'h0029;

	// upper nibble of the status-set reply
	localparam logic [3:0] STATUS_SET_TAG = 4'hA;

	//////////////////////////////////////////////////
	// file bus codes
	localparam logic [CMD_W-1:0] FIO_FILE_TX     = 16'h0053;
	localparam logic [CMD_W-1:0] FIO_FILE_TX_DAT = 16'h0054;
	localparam logic [CMD_W-1:0] FIO_FILE_INDEX  = 16'h0055;

	localparam logic [7:0] UPLOAD_MARK = 8'hAA;

	//////////////////////////////////////////////////
	// ps/2 keyboard bytes
	localparam logic [7:0] KBD_SKIP_HI = 8'hFF;
	localparam logic [7:0] KEY_RELEASE = 8'hF0;
	localparam logic [7:0] KEY_EXTEND  = 8'hE0;

	// multi-byte sequences and the codes that stand in for them
	localparam logic [31:0] KEY_PRNSCR_DN      = 32'hE012E07C;
	localparam logic [31:0] KEY_PRNSCR_UP      = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_DN       = 32'hF014F077;
	localparam logic [9:0]  KEY_PRNSCR_DN_CODE = 10'h37C;
	localparam logic [9:0]  KEY_PRNSCR_UP_CODE = 10'h17C;
	localparam logic [9:0]  KEY_PAUSE_DN_CODE  = 10'h377;

endpackage

//--- logic/hps_cmd_port.sv
// command bus decoder for configuration, joysticks, status and keyboard framing
module hps_cmd_port (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             io_strobe,
	input  logic                             io_enable,
	input  logic [hps_pkg::CMD_W-1:0]        io_din,
	output logic [hps_pkg::CMD_W-1:0]        cmd_dout,

	output logic [hps_pkg::JOY_W-1:0]        joystick_0,
	output logic [hps_pkg::JOY_W-1:0]        joystick_1,
	output logic [hps_pkg::JOY_W-1:0]        joystick_2,
	output logic [hps_pkg::JOY_W-1:0]        joystick_3,
	output logic [hps_pkg::JOY_W-1:0]        joystick_4,
	output logic [hps_pkg::JOY_W-1:0]        joystick_5,
	output logic [1:0]                       buttons,
	output logic                             forced_scandoubler,
	output logic                             direct_video,
	output logic [hps_pkg::STATUS_W-1:0]     status,
	input  logic [hps_pkg::STATUS_W-1:0]     status_in,
	input  logic                             status_set,

	output logic                             kbd_start,
	output logic                             kbd_word,
	output logic                             kbd_end
);
	import hps_pkg::*;

	logic [CMD_W-1:0]           cmd;
	logic [CNT_W-1:0]           byte_cnt;
	logic [CMD_W-1:0]           cfg;
	logic [JOY_W-1:0]           joy [JOY_NUM];
	logic                       joy_hit;
	logic [$clog2(JOY_NUM)-1:0] joy_idx;
	logic [1:0]                 half_idx;
	logic                       half_ok;
	logic                       status_set_d;
	logic                       status_rise;
	logic [3:0]                 stflg;
	logic [STATUS_W-1:0]        status_req;

	//////////////////////////////////////////////////
	// core-facing controls

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];
	assign joystick_5 = joy[5];

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// which joystick the current command addresses
	always_comb begin
		joy_hit = 1'b1;
		joy_idx = '0;
		case (cmd)
			CMD_JOY_0: joy_idx = 3'd0;
			CMD_JOY_1: joy_idx = 3'd1;
			CMD_JOY_2: joy_idx = 3'd2;
			CMD_JOY_3: joy_idx = 3'd3;
			CMD_JOY_4: joy_idx = 3'd4;
			CMD_JOY_5: joy_idx = 3'd5;
			default:   joy_hit = 1'b0;
		endcase
	end

	// payload words 1..4 map onto the four 16-bit quarters of a status word
	assign half_idx = 2'(byte_cnt - 1'b1);
	assign half_ok  = (byte_cnt <= CNT_W'(4));

	//////////////////////////////////////////////////
	// command capture and register writes

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd      <= '0;
			byte_cnt <= '0;
			cmd_dout <= '0;
			cfg      <= '0;
			status   <= '0;
			for (int i = 0; i < JOY_NUM; i++) begin
				joy[i] <= '0;
			end
		end else if (!io_enable) begin
			cmd      <= '0;
			byte_cnt <= '0;
			cmd_dout <= '0;
		end else if (io_strobe) begin
			cmd_dout <= '0;
			if (!(&byte_cnt)) byte_cnt <= byte_cnt + 1'b1;

			if (byte_cnt == '0) begin
				cmd <= io_din;
				// change counter goes back with the command word
				if (io_din == CMD_STATUS_SET) begin
					cmd_dout <= {{(CMD_W-8){1'b0}}, STATUS_SET_TAG, stflg};
				end
			end else begin
				// low half first, every later word lands in the high half
				if (joy_hit) begin
					if (byte_cnt == CNT_W'(1)) joy[joy_idx][CMD_W-1:0] <= io_din;
					else joy[joy_idx][JOY_W-1:CMD_W] <= io_din;
				end

				case (cmd)
					CMD_CFG: cfg <= io_din;
					CMD_STATUS: begin
						if (half_ok) status[half_idx*CMD_W +: CMD_W] <= io_din;
					end
					CMD_STATUS_SET: begin
						if (half_ok) cmd_dout <= status_req[half_idx*CMD_W +: CMD_W];
					end
					default: begin
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// status-set request from the core

	assign status_rise = status_set && !status_set_d;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status_set_d <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_rise) stflg <= stflg + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_rise) status_req <= status_in;
	end

	//////////////////////////////////////////////////
	// keyboard transaction framing

	assign kbd_start = io_enable && io_strobe && (byte_cnt == '0) && (io_din == CMD_KBD);
	assign kbd_word  = io_enable && io_strobe && (byte_cnt != '0) && (cmd == CMD_KBD);
	// cmd clears on the same edge, so this lasts one cycle
	assign kbd_end   = !io_enable && (cmd == CMD_KBD);

	// a saturated counter stays put until the transaction closes
	a_cnt_no_wrap: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(io_enable && (&byte_cnt)) |=> (&byte_cnt)
	) else $error("word counter wrapped");

endmodule

//--- logic/hps_kbd_event.sv
// assembles ps/2 scan bytes from the host into the toggling key event word
module hps_kbd_event (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      kbd_start,
	input  logic                      kbd_word,
	input  logic                      kbd_end,
	input  logic [hps_pkg::CMD_W-1:0] io_din,
	output logic [10:0]               ps2_key
);
	import hps_pkg::*;

	logic [31:0] raw;
	logic        skip;
	logic        skip_word;
	logic        pressed;
	logic        extended;
	logic [10:0] key_next;

	assign skip_word = (io_din[15:8] == KBD_SKIP_HI);

	// skip flag lives for one transaction
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			skip <= 1'b0;
		end else if (kbd_start) begin
			skip <= 1'b0;
		end else if (kbd_word && skip_word) begin
			skip <= 1'b1;
		end
	end

	// newest byte sits in the low end
	always_ff @(posedge clk_sys) begin
		if (kbd_start) begin
			raw <= '0;
		end else if (kbd_word && !skip_word && !skip) begin
			raw <= {raw[23:0], io_din[7:0]};
		end
	end

	//////////////////////////////////////////////////
	// event decode

	assign pressed  = (raw[15:8] != KEY_RELEASE);
	assign extended = pressed ? (raw[15:8] == KEY_EXTEND) : (raw[23:16] == KEY_EXTEND);

	always_comb begin
		key_next = {~ps2_key[10], pressed, extended, raw[7:0]};
		// print screen and pause do not fit the prefix scheme
		case (raw)
			KEY_PRNSCR_DN: key_next[9:0] = KEY_PRNSCR_DN_CODE;
			KEY_PRNSCR_UP: key_next[9:0] = KEY_PRNSCR_UP_CODE;
			KEY_PAUSE_DN:  key_next[9:0] = KEY_PAUSE_DN_CODE;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ps2_key <= '0;
		end else if (kbd_end && !skip) begin
			ps2_key <= key_next;
		end
	end

	// command port opens the frame on its first word only
	a_start_word_apart: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(kbd_start && kbd_word)
	) else $error("keyboard payload word together with start");

endmodule

//--- logic/hps_file_port.sv
// file port sequencing index, download and upload with ioctl strobes
module hps_file_port (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       io_strobe,
	input  logic                       fp_enable,
	input  logic [hps_pkg::CMD_W-1:0]  io_din,
	output logic [hps_pkg::CMD_W-1:0]  fp_dout,

	output logic [hps_pkg::CMD_W-1:0]  ioctl_index,
	output logic                       ioctl_download,
	output logic                       ioctl_upload,
	output logic                       ioctl_wr,
	output logic                       ioctl_rd,
	output logic [hps_pkg::ADDR_W-1:0] ioctl_addr,
	output logic [hps_pkg::DATA_W-1:0] ioctl_dout,
	input  logic [hps_pkg::DATA_W-1:0] ioctl_din
);
	import hps_pkg::*;

	logic [CMD_W-1:0]  cmd;
	logic              has_cmd;
	logic [1:0]        cnt;
	logic [ADDR_W-1:0] addr;
	logic              wr;

	logic              stb;
	logic              cmd_stb;
	logic              is_tx;
	logic              is_dat;
	logic              is_idx;
	logic              tx_up;
	logic              tx_dn;
	logic              tx_stop;

	//////////////////////////////////////////////////
	// word decode

	assign stb     = fp_enable && io_strobe;
	assign cmd_stb = stb && !has_cmd;
	assign is_tx   = stb && has_cmd && (cmd == FIO_FILE_TX);
	assign is_dat  = stb && has_cmd && (cmd == FIO_FILE_TX_DAT);
	assign is_idx  = stb && has_cmd && (cmd == FIO_FILE_INDEX);

	// first FILE_TX word picks upload, download or stop
	assign tx_up   = is_tx && (cnt == 2'd0) && (io_din[7:0] == UPLOAD_MARK);
	assign tx_dn   = is_tx && (cnt == 2'd0) && (io_din[7:0] != UPLOAD_MARK) && (|io_din[7:0]);
	assign tx_stop = is_tx && (cnt == 2'd0) && (io_din[7:0] == 8'h00);

	//////////////////////////////////////////////////
	// transfer state and strobes

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			has_cmd        <= 1'b0;
			cnt            <= '0;
			wr             <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_rd       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_upload   <= 1'b0;
			fp_dout        <= '0;
		end else begin
			// write pulse trails the address and data by a cycle
			ioctl_wr <= wr;
			wr       <= 1'b0;
			ioctl_rd <= 1'b0;

			if (!fp_enable) has_cmd <= 1'b0;
			else if (cmd_stb) has_cmd <= 1'b1;

			if (cmd_stb) cnt <= '0;
			else if (is_tx && cnt != 2'd3) cnt <= cnt + 2'd1;

			if (tx_up) begin
				ioctl_upload <= 1'b1;
				ioctl_rd     <= 1'b1;
			end
			if (tx_dn) ioctl_download <= 1'b1;
			if (tx_stop) begin
				ioctl_download <= 1'b0;
				ioctl_upload   <= 1'b0;
			end

			if (is_dat && ioctl_download) begin
				wr <= 1'b1;
			end else if (is_dat && ioctl_upload) begin
				fp_dout  <= {{(CMD_W-DATA_W){1'b0}}, ioctl_din};
				ioctl_rd <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// command, index, address and data

	always_ff @(posedge clk_sys) begin
		if (cmd_stb) cmd <= io_din;
		if (is_idx) ioctl_index <= io_din;

		if (tx_up) ioctl_addr <= '0;
		if (tx_dn) addr <= '0;
		// leave the address just past the last byte written
		if (tx_stop && ioctl_download) ioctl_addr <= addr;

		if (is_tx && cnt == 2'd1) begin
			ioctl_addr[CMD_W-1:0] <= io_din;
			addr[CMD_W-1:0]       <= io_din;
		end
		if (is_tx && cnt == 2'd2) begin
			ioctl_addr[ADDR_W-1:CMD_W] <= io_din[ADDR_W-CMD_W-1:0];
			addr[ADDR_W-1:CMD_W]       <= io_din[ADDR_W-CMD_W-1:0];
		end

		if (is_dat && ioctl_download) begin
			ioctl_addr <= addr;
			ioctl_dout <= io_din[DATA_W-1:0];
			addr       <= addr + 1'b1;
		end else if (is_dat && ioctl_upload) begin
			ioctl_addr <= ioctl_addr + 1'b1;
		end
	end

	a_wr_in_download: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download
	) else $error("write pulse outside download");

	a_one_direction: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(ioctl_download && ioctl_upload)
	) else $error("download and upload both active");

endmodule

//--- logic/hps_io.sv
// host I/O bridge top joining the command port, keyboard decoder and file port
module hps_io (
	input  logic                             clk_sys,
	input  logic                             rst_n,

	// host bus
	input  logic                             io_strobe,
	input  logic                             io_enable,
	input  logic                             fp_enable,
	input  logic [hps_pkg::CMD_W-1:0]        io_din,
	output logic [hps_pkg::CMD_W-1:0]        io_dout,

	// core controls
	output logic [hps_pkg::JOY_W-1:0]        joystick_0,
	output logic [hps_pkg::JOY_W-1:0]        joystick_1,
	output logic [hps_pkg::JOY_W-1:0]        joystick_2,
	output logic [hps_pkg::JOY_W-1:0]        joystick_3,
	output logic [hps_pkg::JOY_W-1:0]        joystick_4,
	output logic [hps_pkg::JOY_W-1:0]        joystick_5,
	output logic [1:0]                       buttons,
	output logic                             forced_scandoubler,
	output logic                             direct_video,
	output logic [hps_pkg::STATUS_W-1:0]     status,
	input  logic [hps_pkg::STATUS_W-1:0]     status_in,
	input  logic                             status_set,
	output logic [10:0]                      ps2_key,

	// file transfer
	output logic                             ioctl_download,
	output logic                             ioctl_upload,
	output logic                             ioctl_wr,
	output logic                             ioctl_rd,
	output logic [hps_pkg::CMD_W-1:0]        ioctl_index,
	output logic [hps_pkg::ADDR_W-1:0]       ioctl_addr,
	output logic [hps_pkg::DATA_W-1:0]       ioctl_dout,
	input  logic [hps_pkg::DATA_W-1:0]       ioctl_din
);
	import hps_pkg::*;

	logic [CMD_W-1:0] cmd_dout;
	logic [CMD_W-1:0] fp_dout;
	logic             kbd_start;
	logic             kbd_word;
	logic             kbd_end;

	hps_cmd_port u_cmd_port (.*);

	hps_kbd_event u_kbd_event (.*);

	hps_file_port u_file_port (.*);

	// file port owns the read-back word while its transaction is open
	assign io_dout = fp_enable ? fp_dout : cmd_dout;

endmodule

//--- sim/tb_hps_io.sv
// testbench for the host I/O bridge running command and file transactions from a table
module tb_hps_io;
	import hps_pkg::*;

	localparam int RST_CYCLES = 8;

	typedef enum int {
		K_JOY, K_CFG, K_STAT, K_STSET, K_KEY, K_SKIP, K_IDX,
		K_DL_ON, K_DL_DAT, K_DL_END, K_UP_ON, K_UP_DAT, K_UP_END
	} kind_e;

	// one host transaction, word 0 in the low 16 bits
	typedef struct packed {
		logic        fbus;
		int          kind;
		int          arg;
		int          n;
		logic [95:0] w;
	} txn_t;

	logic                clk_sys    = 1'b0;
	logic                rst_n      = 1'b0;
	logic                io_strobe  = 1'b0;
	logic                io_enable  = 1'b0;
	logic                fp_enable  = 1'b0;
	logic [CMD_W-1:0]    io_din     = '0;
	logic [CMD_W-1:0]    io_dout;
	logic [JOY_W-1:0]    joystick_0;
	logic [JOY_W-1:0]    joystick_1;
	logic [JOY_W-1:0]    joystick_2;
	logic [JOY_W-1:0]    joystick_3;
	logic [JOY_W-1:0]    joystick_4;
	logic [JOY_W-1:0]    joystick_5;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	logic [STATUS_W-1:0] status;
	logic [STATUS_W-1:0] status_in  = '0;
	logic                status_set = 1'b0;
	logic [10:0]         ps2_key;
	logic                ioctl_download;
	logic                ioctl_upload;
	logic                ioctl_wr;
	logic                ioctl_rd;
	logic [CMD_W-1:0]    ioctl_index;
	logic [ADDR_W-1:0]   ioctl_addr;
	logic [DATA_W-1:0]   ioctl_dout;
	logic [DATA_W-1:0]   ioctl_din;

	// reference model state
	txn_t                tbl [$];
	string               names [$];
	logic [31:0]         joy_exp [JOY_NUM];
	logic [63:0]         st_last    = '0;
	logic [3:0]          set_cnt    = '0;
	logic [10:0]         key_exp    = '0;
	logic [ADDR_W-1:0]   dl_off     = '0;
	logic [15:0]         lfsr       = 16'd16157;
	logic [34:0]         wr_q [$];
	int                  dl_n       = 0;
	int                  up_n       = 0;
	int                  wr_seen    = 0;
	int                  rd_seen    = 0;
	int                  test_err   = 0;
	int                  pass_cnt   = 0;
	int                  fail_cnt   = 0;
	int                  total      = 0;
	int                  cycles     = 0;
	int                  limit      = 0;

	hps_io UUT (.*);

	// host memory seen by an upload
	assign ioctl_din = ioctl_addr[7:0] ^ 8'h5A;

	always #2 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// helpers

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		// taps 16 14 13 11
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic flag_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		test_err++;
	endtask

	task automatic add_txn(input string name, input logic fbus, input int kind,
		input int arg, input int n, input logic [15:0] w0, w1, w2, w3, w4, w5);
		txn_t t;
		t.fbus = fbus;
		t.kind = kind;
		t.arg  = arg;
		t.n    = n;
		t.w    = {w5, w4, w3, w2, w1, w0};
		tbl.push_back(t);
		names.push_back(name);
		total += n;
	endtask

	task automatic close_test(input string name);
		if (test_err == 0) begin
			pass_cnt++;
			$display("test %s passed", name);
		end else begin
			fail_cnt++;
			$display("test %s failed with %0d errors", name, test_err);
		end
		test_err = 0;
	endtask

	// one strobe, then three idle cycles
	task automatic send_word(input logic [15:0] word, output logic [15:0] reply);
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= word;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(negedge clk_sys);
		reply = io_dout;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_txn(input txn_t t);
		logic [15:0] word;
		logic [15:0] reply;
		logic [15:0] exp_reply;
		logic        chk;
		logic [7:0]  b;
		if (t.kind == K_DL_ON) wr_seen = 0;
		if (t.kind == K_UP_ON) rd_seen = 0;
		// status_set rising edges ahead of the read-back
		for (int p = 0; t.kind == K_STSET && p < t.arg; p++) begin
			set_cnt = set_cnt + 1'b1;
			st_last = {16'(p), 16'hC0DE, 12'h000, set_cnt, 16'h5A00 + 16'(t.arg)};
			@(posedge clk_sys);
			status_set <= 1'b1;
			status_in  <= st_last;
			@(posedge clk_sys);
			status_set <= 1'b0;
		end
		@(posedge clk_sys);
		if (t.fbus) fp_enable <= 1'b1;
		else io_enable <= 1'b1;
		for (int k = 0; k < t.n; k++) begin
			word = t.w[16*k +: 16];
			if (t.kind == K_DL_DAT && k > 0) begin
				take_byte(b);
				word = {8'h00, b};
				wr_q.push_back({dl_off + ADDR_W'(dl_n), b});
				dl_n++;
			end
			send_word(word, reply);
			chk = 1'b1;
			exp_reply = '0;
			if (t.kind == K_STSET && k == 0) begin
				exp_reply = {8'h00, STATUS_SET_TAG, set_cnt};
			end else if (t.kind == K_STSET) begin
				exp_reply = st_last[16*(k-1) +: 16];
			end else if (t.kind == K_UP_DAT && k > 0) begin
				exp_reply = {8'h00, 8'(up_n) ^ 8'h5A};
				up_n++;
			end else begin
				chk = !t.fbus && (k == 0);
			end
			if (chk && reply !== exp_reply) flag_mismatch("io_dout", reply, exp_reply);
		end
		@(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);

		case (t.kind)
			K_JOY: begin
				joy_exp[t.arg] = {t.w[47:32], t.w[31:16]};
				if (joystick_0 !== joy_exp[0]) flag_mismatch("joystick_0", joystick_0, joy_exp[0]);
				if (joystick_1 !== joy_exp[1]) flag_mismatch("joystick_1", joystick_1, joy_exp[1]);
				if (joystick_2 !== joy_exp[2]) flag_mismatch("joystick_2", joystick_2, joy_exp[2]);
				if (joystick_3 !== joy_exp[3]) flag_mismatch("joystick_3", joystick_3, joy_exp[3]);
				if (joystick_4 !== joy_exp[4]) flag_mismatch("joystick_4", joystick_4, joy_exp[4]);
				if (joystick_5 !== joy_exp[5]) flag_mismatch("joystick_5", joystick_5, joy_exp[5]);
			end
			K_CFG: if ({direct_video, forced_scandoubler, buttons} !== {t.w[26], t.w[20], t.w[17:16]})
				flag_mismatch("direct_video/forced_scandoubler/buttons",
					{direct_video, forced_scandoubler, buttons}, {t.w[26], t.w[20], t.w[17:16]});
			K_STAT: if (status !== t.w[79:16]) flag_mismatch("status", status, t.w[79:16]);
			K_KEY: begin
				key_exp = {~key_exp[10], 10'(t.arg)};
				if (ps2_key !== key_exp) flag_mismatch("ps2_key", ps2_key, key_exp);
			end
			K_SKIP: if (ps2_key !== key_exp) flag_mismatch("ps2_key", ps2_key, key_exp);
			K_IDX: if (ioctl_index !== t.w[31:16]) flag_mismatch("ioctl_index", ioctl_index, t.w[31:16]);
			K_DL_ON: begin
				dl_off = {t.w[58:48], t.w[47:32]};
				dl_n   = 0;
				if (ioctl_download !== 1'b1) flag_mismatch("ioctl_download", ioctl_download, 1);
			end
			K_DL_DAT: if (wr_seen != dl_n) flag_mismatch("ioctl_wr count", wr_seen, dl_n);
			K_DL_END: begin
				if (ioctl_download !== 1'b0) flag_mismatch("ioctl_download", ioctl_download, 0);
				if (ioctl_addr !== dl_off + ADDR_W'(dl_n))
					flag_mismatch("ioctl_addr", ioctl_addr, dl_off + ADDR_W'(dl_n));
			end
			K_UP_ON: begin
				up_n = 0;
				if (ioctl_upload !== 1'b1) flag_mismatch("ioctl_upload", ioctl_upload, 1);
				if (rd_seen != 1) flag_mismatch("ioctl_rd count", rd_seen, 1);
			end
			K_UP_DAT: if (rd_seen != up_n + 1) flag_mismatch("ioctl_rd count", rd_seen, up_n + 1);
			K_UP_END: if (ioctl_upload !== 1'b0) flag_mismatch("ioctl_upload", ioctl_upload, 0);
			default: begin
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// ioctl strobe monitor

	always @(negedge clk_sys) begin
		logic [34:0] e;
		if (rst_n && ioctl_rd) rd_seen++;
		if (rst_n && ioctl_wr) begin
			wr_seen++;
			if (wr_q.size() == 0) begin
				$display("write pulse at address %h with no byte sent for it", ioctl_addr);
				test_err++;
			end else begin
				e = wr_q.pop_front();
				if ({ioctl_addr, ioctl_dout} !== e)
					flag_mismatch("ioctl_addr/ioctl_dout", {ioctl_addr, ioctl_dout}, e);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("run stopped at the cycle limit of %0d with tests unfinished", limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// test table and main sequence

	initial begin
		foreach (joy_exp[j]) joy_exp[j] = '0;
		add_txn("joy0", 0, K_JOY, 0, 3, CMD_JOY_0, 16'h1234, 16'h8001, 0, 0, 0);
		add_txn("joy1", 0, K_JOY, 1, 3, CMD_JOY_1, 16'h5678, 16'h4002, 0, 0, 0);
		add_txn("joy2", 0, K_JOY, 2, 3, CMD_JOY_2, 16'h9ABC, 16'h2004, 0, 0, 0);
		add_txn("joy3", 0, K_JOY, 3, 3, CMD_JOY_3, 16'hDEF0, 16'h1008, 0, 0, 0);
		add_txn("joy4", 0, K_JOY, 4, 3, CMD_JOY_4, 16'h0F0F, 16'h0810, 0, 0, 0);
		add_txn("joy5", 0, K_JOY, 5, 3, CMD_JOY_5, 16'hF0F0, 16'h0420, 0, 0, 0);
		add_txn("cfg a", 0, K_CFG, 0, 2, CMD_CFG, 16'h0413, 0, 0, 0, 0);
		add_txn("cfg b", 0, K_CFG, 0, 2, CMD_CFG, 16'h0002, 0, 0, 0, 0);
		add_txn("status", 0, K_STAT, 0, 5, CMD_STATUS, 16'h1111, 16'h2222, 16'h3333, 16'h4444, 0);
		add_txn("status set x3", 0, K_STSET, 3, 5, CMD_STATUS_SET, 0, 0, 0, 0, 0);
		add_txn("status set x2", 0, K_STSET, 2, 5, CMD_STATUS_SET, 0, 0, 0, 0, 0);
		add_txn("key e0 70", 0, K_KEY, 10'h370, 3, CMD_KBD, 16'h00E0, 16'h0070, 0, 0, 0);
		add_txn("key e0 f0 70", 0, K_KEY, 10'h170, 4, CMD_KBD, 16'h00E0, 16'h00F0, 16'h0070, 0, 0);
		add_txn("key skip", 0, K_SKIP, 0, 4, CMD_KBD, 16'h00E0, 16'hFF00, 16'h0071, 0, 0);
		add_txn("key prnscr", 0, K_KEY, 10'h37C, 5, CMD_KBD, 16'h00E0, 16'h0012, 16'h00E0,
			16'h007C, 0);
		add_txn("file index", 1, K_IDX, 0, 2, FIO_FILE_INDEX, 16'h0007, 0, 0, 0, 0);
		add_txn("dl start", 1, K_DL_ON, 0, 4, FIO_FILE_TX, 16'h0001, 16'h1230, 16'h0001, 0, 0);
		add_txn("dl data a", 1, K_DL_DAT, 0, 6, FIO_FILE_TX_DAT, 0, 0, 0, 0, 0);
		add_txn("dl data b", 1, K_DL_DAT, 0, 5, FIO_FILE_TX_DAT, 0, 0, 0, 0, 0);
		add_txn("dl end", 1, K_DL_END, 0, 2, FIO_FILE_TX, 16'h0000, 0, 0, 0, 0);
		add_txn("ul start", 1, K_UP_ON, 0, 2, FIO_FILE_TX, 16'h00AA, 0, 0, 0, 0);
		add_txn("ul data a", 1, K_UP_DAT, 0, 5, FIO_FILE_TX_DAT, 0, 0, 0, 0, 0);
		add_txn("ul data b", 1, K_UP_DAT, 0, 3, FIO_FILE_TX_DAT, 0, 0, 0, 0, 0);
		add_txn("ul end", 1, K_UP_END, 0, 2, FIO_FILE_TX, 16'h0000, 0, 0, 0, 0);
		limit = 2 * total * 4 + RST_CYCLES;

		repeat (RST_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		if ({ioctl_wr, ioctl_rd, ioctl_download, ioctl_upload, io_dout, ps2_key} !== '0)
			flag_mismatch("ioctl strobes/io_dout/ps2_key",
				{ioctl_wr, ioctl_rd, ioctl_download, ioctl_upload, io_dout, ps2_key}, 0);
		if (|{status, joystick_0, joystick_1, joystick_2, joystick_3, joystick_4, joystick_5,
			direct_video, forced_scandoubler, buttons} !== 1'b0)
			flag_mismatch("status/joysticks/cfg after reset", 1, 0);
		close_test("reset");

		for (int i = 0; i < tbl.size(); i++) begin
			run_txn(tbl[i]);
			close_test(names[i]);
		end

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- project.f
logic/hps_pkg.sv
logic/hps_cmd_port.sv
logic/hps_kbd_event.sv
logic/hps_file_port.sv
logic/hps_io.sv
sim/tb_hps_io.sv

//--- Bender.yml
package:
  name: hps_io

sources:
  - logic/hps_pkg.sv
  - logic/hps_cmd_port.sv
  - logic/hps_kbd_event.sv
  - logic/hps_file_port.sv
  - logic/hps_io.sv
  - target: simulation
    files:
      - sim/tb_hps_io.sv
